//--- project.f
+incdir+.
cam_pkg.sv
cam_byte_pairer.sv
cam_coord_tracker.sv
phrase_builder.sv
cam_write_top.sv
cam_write_chk.sv
tb_cam_write.sv

//--- run.sh
#!/bin/sh
# build the camera write testbench with Verilator and run it
# the run passes only if the pass line appears in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_cam_write \
   -f project.f -o tb_cam_write \
   && ./obj_dir/tb_cam_write | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null \
   && { echo "simulation passed"; exit 0; } \
   || { echo "simulation failed"; exit 1; }

//--- tb_cam_write.sv
`timescale 1ns/1ps
`include "cam_settings.svh"
`default_nettype none

module tb_cam_write;

   localparam int CLK_PERIOD = 4;
   localparam int HALF_BYTE_CYCLES = 4;
   localparam int PHRASE_COUNT = `CAM_FRAME_W * `CAM_FRAME_H / `CAM_PIX_PER_PHRASE;
   localparam int BYTES_PER_FRAME = `CAM_FRAME_W * `CAM_FRAME_H * 2;
   // frames over all tests: 1 + 2 + 2 + 1
   localparam int TOTAL_FRAMES = 6;
   localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * BYTES_PER_FRAME * 8 * 2;
   localparam int DRAIN_LIMIT = 200;

   logic sys_clk;
   logic sys_rst;
   logic cam_pclk;
   logic cam_hs;
   logic cam_vs;
   cam_pkg::cam_byte_t cam_data;
   logic freeze;
   logic out_ready;
   cam_pkg::phrase_beat_t out_beat;
   logic out_valid;
   cam_pkg::drop_count_t drop_count;

   cam_pkg::phrase_beat_t expected_q[$];
   cam_pkg::phrase_beat_t exp_beat;
   logic [31:0] lcg_state;
   int error_count;
   int check_count;
   int test_count;

   cam_write_top u_dut (
      .sys_clk      (sys_clk),
      .sys_rst      (sys_rst),
      .cam_pclk_i   (cam_pclk),
      .cam_hs_i     (cam_hs),
      .cam_vs_i     (cam_vs),
      .cam_data_i   (cam_data),
      .freeze_i     (freeze),
      .out_ready_i  (out_ready),
      .out_beat_o   (out_beat),
      .out_valid_o  (out_valid),
      .drop_count_o (drop_count)
   );

   initial sys_clk = 1'b0;
   always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // wen in bit 0, frame length above it, base address in the top field
   function automatic cam_pkg::phrase_beat_t command_beat();
      cam_pkg::phrase_beat_t beat;
      beat = '0;
      beat.tuser = 1'b1;
      beat.data[0] = 1'b1;
      beat.data[1 +: `CAM_ADDR_W] = `CAM_ADDR_W'(PHRASE_COUNT);
      beat.data[1 + `CAM_ADDR_W +: `CAM_ADDR_W] = `CAM_FB_BASE;
      return beat;
   endfunction

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge sys_clk);
   endtask

   // one pclk period, data set up while pclk is low
   task automatic send_byte(input cam_pkg::cam_byte_t value);
      cam_pclk = 1'b0;
      cam_data = value;
      wait_cycles(HALF_BYTE_CYCLES);
      cam_pclk = 1'b1;
      wait_cycles(HALF_BYTE_CYCLES);
   endtask

   task automatic send_frame(input logic frozen, input logic want_cmd, input logic want_data);
      cam_pkg::pixel_t pix;
      cam_pkg::phrase_beat_t beat;
      int slot;
      freeze = frozen;
      cam_vs = 1'b1;
      wait_cycles(8);
      cam_vs = 1'b0;
      wait_cycles(4);
      if (want_cmd) begin
         expected_q.push_back(command_beat());
      end
      beat = '0;
      slot = 0;
      for (int row = 0; row < `CAM_FRAME_H; row++) begin
         cam_hs = 1'b1;
         for (int col = 0; col < `CAM_FRAME_W; col++) begin
            lcg_state = lcg_next(lcg_state);
            pix = lcg_state[31:16];
            beat.data[slot * `CAM_PIX_W +: `CAM_PIX_W] = pix;
            if (slot == `CAM_PIX_PER_PHRASE - 1) begin
               if (want_data) begin
                  expected_q.push_back(beat);
               end
               slot = 0;
            end else begin
               slot++;
            end
            // high byte goes out first
            send_byte(pix[15:8]);
            send_byte(pix[7:0]);
         end
         cam_pclk = 1'b0;
         wait_cycles(8);
         cam_hs = 1'b0;
         wait_cycles(8);
      end
   endtask

   task automatic wait_drained(input string name);
      int waited;
      waited = 0;
      while (expected_q.size() != 0 && waited < DRAIN_LIMIT) begin
         @(negedge sys_clk);
         waited++;
      end
      if (expected_q.size() != 0) begin
         $display("%s: %0d expected beats never arrived", name, expected_q.size());
         error_count++;
         expected_q.delete();
      end
      // room for stray beats to show up
      wait_cycles(16);
   endtask

   task automatic report_test(input string name, input int errors_before);
      test_count++;
      if (error_count == errors_before) begin
         $display("test %0d %s: ok", test_count, name);
      end else begin
         $display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
      end
   endtask

   // every accepted beat is matched against the head of the queue
   always @(posedge sys_clk) begin
      if (!sys_rst && out_valid && out_ready) begin
         if (expected_q.size() == 0) begin
            $display("beat accepted with nothing expected, data %h", out_beat.data);
            error_count++;
         end else begin
            exp_beat = expected_q.pop_front();
            check_count++;
            assert (out_beat.tuser == exp_beat.tuser) else begin
               $display("[ERROR] out_beat_o.tuser expected %h got %h",
                        exp_beat.tuser, out_beat.tuser);
               error_count++;
            end
            assert (out_beat.data == exp_beat.data) else begin
               $display("[ERROR] out_beat_o.data expected %h got %h",
                        exp_beat.data, out_beat.data);
               error_count++;
            end
         end
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      int errors_before;
      sys_rst = 1'b1;
      cam_pclk = 1'b0;
      cam_hs = 1'b0;
      cam_vs = 1'b0;
      cam_data = '0;
      freeze = 1'b0;
      out_ready = 1'b1;
      lcg_state = 32'h5c13_2d3b;
      error_count = 0;
      check_count = 0;
      test_count = 0;
      repeat (3) @(negedge sys_clk);
      sys_rst = 1'b0;
      @(negedge sys_clk);

      errors_before = error_count;
      check_count += 2;
      assert (out_valid == 1'b0) else begin
         $display("[ERROR] out_valid_o expected %h got %h", 1'b0, out_valid);
         error_count++;
      end
      assert (drop_count == '0) else begin
         $display("[ERROR] drop_count_o expected %h got %h", 8'h00, drop_count);
         error_count++;
      end
      report_test("reset state", errors_before);

      errors_before = error_count;
      send_frame(1'b0, 1'b1, 1'b1);
      wait_drained("single frame");
      report_test("single frame", errors_before);

      errors_before = error_count;
      send_frame(1'b0, 1'b1, 1'b1);
      send_frame(1'b0, 1'b1, 1'b1);
      wait_drained("two frames");
      report_test("two frames", errors_before);

      errors_before = error_count;
      send_frame(1'b1, 1'b0, 1'b0);
      send_frame(1'b0, 1'b1, 1'b1);
      wait_drained("freeze");
      report_test("frozen then live frame", errors_before);

      // output blocked for a whole frame, only the command survives
      errors_before = error_count;
      out_ready = 1'b0;
      send_frame(1'b0, 1'b1, 1'b0);
      wait_cycles(16);
      check_count += 3;
      assert (out_valid == 1'b1) else begin
         $display("[ERROR] out_valid_o expected %h got %h", 1'b1, out_valid);
         error_count++;
      end
      assert (out_beat.tuser == 1'b1) else begin
         $display("[ERROR] out_beat_o.tuser expected %h got %h", 1'b1, out_beat.tuser);
         error_count++;
      end
      assert (drop_count == cam_pkg::drop_count_t'(PHRASE_COUNT)) else begin
         $display("[ERROR] drop_count_o expected %h got %h",
                  cam_pkg::drop_count_t'(PHRASE_COUNT), drop_count);
         error_count++;
      end
      out_ready = 1'b1;
      wait_drained("back-pressure");
      report_test("back-pressure", errors_before);

      $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
      if (error_count == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- cam_write_chk.sv
`timescale 1ns/1ps
`default_nettype none

module cam_write_chk (
   input logic                  sys_clk,
   input logic                  sys_rst,
   input logic                  valid_i,
   input logic                  ready_i,
   input cam_pkg::phrase_beat_t beat_i,
   input cam_pkg::drop_count_t  drop_count_i
);

   // a beat offered and not taken stays put
   property hold_under_backpressure;
      @(posedge sys_clk) disable iff (sys_rst)
         valid_i && !ready_i |=> valid_i && $stable(beat_i);
   endproperty

   property reset_clears_outputs;
      @(posedge sys_clk) sys_rst |=> !valid_i && drop_count_i == '0;
   endproperty

   a_hold: assert property (hold_under_backpressure)
      else $error("output beat changed or was withdrawn while stalled");
   a_reset: assert property (reset_clears_outputs)
      else $error("output valid or drop counter not cleared by reset");

endmodule

bind cam_write_top cam_write_chk u_chk (
   .sys_clk      (sys_clk),
   .sys_rst      (sys_rst),
   .valid_i      (out_valid_o),
   .ready_i      (out_ready_i),
   .beat_i       (out_beat_o),
   .drop_count_i (drop_count_o)
);

`default_nettype wire

//--- cam_write_top.sv
`timescale 1ns/1ps
`default_nettype none

module cam_write_top (
   input  logic                  sys_clk,
   input  logic                  sys_rst,
   input  logic                  cam_pclk_i,
   input  logic                  cam_hs_i,
   input  logic                  cam_vs_i,
   input  cam_pkg::cam_byte_t    cam_data_i,
   input  logic                  freeze_i,
   input  logic                  out_ready_i,
   output cam_pkg::phrase_beat_t out_beat_o,
   output logic                  out_valid_o,
   output cam_pkg::drop_count_t  drop_count_o
);

   logic pix_valid;
   cam_pkg::pixel_t pix_data;
   logic line_active;
   logic frame_blank;
   cam_pkg::coord_pixel_t coord_pix;

   // camera pins to RGB565 pixels
   cam_byte_pairer u_pairer (
      .sys_clk       (sys_clk),
      .sys_rst       (sys_rst),
      .cam_pclk_i    (cam_pclk_i),
      .cam_hs_i      (cam_hs_i),
      .cam_vs_i      (cam_vs_i),
      .cam_data_i    (cam_data_i),
      .pix_valid_o   (pix_valid),
      .pix_data_o    (pix_data),
      .line_active_o (line_active),
      .frame_blank_o (frame_blank)
   );

   cam_coord_tracker u_tracker (
      .sys_clk       (sys_clk),
      .sys_rst       (sys_rst),
      .pix_valid_i   (pix_valid),
      .pix_data_i    (pix_data),
      .line_active_i (line_active),
      .frame_blank_i (frame_blank),
      .coord_pix_o   (coord_pix)
   );

   // command plus data phrases toward the frame buffer
   phrase_builder u_builder (
      .sys_clk      (sys_clk),
      .sys_rst      (sys_rst),
      .coord_pix_i  (coord_pix),
      .freeze_i     (freeze_i),
      .out_ready_i  (out_ready_i),
      .out_beat_o   (out_beat_o),
      .out_valid_o  (out_valid_o),
      .drop_count_o (drop_count_o)
   );

endmodule

`default_nettype wire

//--- phrase_builder.sv
`timescale 1ns/1ps
`include "cam_settings.svh"
`default_nettype none

module phrase_builder (
   input  logic                  sys_clk,
   input  logic                  sys_rst,
   input  cam_pkg::coord_pixel_t coord_pix_i,
   input  logic                  freeze_i,
   input  logic                  out_ready_i,
   output cam_pkg::phrase_beat_t out_beat_o,
   output logic                  out_valid_o,
   output cam_pkg::drop_count_t  drop_count_o
);

   localparam int SLOT_W = $clog2(`CAM_PIX_PER_PHRASE);
   localparam int LAST_SLOT = `CAM_PIX_PER_PHRASE - 1;
   localparam int FRAME_PHRASES = `CAM_FRAME_W * `CAM_FRAME_H / `CAM_PIX_PER_PHRASE;
   localparam int CMD_PAD = `CAM_PHRASE_W - $bits(cam_pkg::channel_update_t);

   logic freeze_q;
   logic new_frame;
   logic frame_live;
   logic [SLOT_W-1:0] slot_q;
   logic [SLOT_W-1:0] slot_base;
   cam_pkg::pixel_t pack_q [LAST_SLOT];
   cam_pkg::channel_update_t cmd;
   cam_pkg::phrase_t data_phrase;
   logic load_cmd;
   logic load_data;
   logic load_any;
   logic can_load;
   cam_pkg::phrase_beat_t next_beat;
   cam_pkg::phrase_beat_t beat_q;
   cam_pkg::out_state_t state;

   assign new_frame = coord_pix_i.valid & coord_pix_i.newframe;

   // freeze is decided by the first pixel, the rest of the frame follows it
   assign frame_live = new_frame ? ~freeze_i : ~freeze_q;

   // a new frame restarts packing at slot 0 with its own first pixel
   assign slot_base = new_frame ? '0 : slot_q;

   assign load_cmd = new_frame & ~freeze_i;
   assign load_data = coord_pix_i.valid & frame_live & (slot_base == SLOT_W'(LAST_SLOT));
   assign load_any = load_cmd | load_data;

   // register frees up in the same cycle it hands off its beat
   assign can_load = (state == cam_pkg::OUT_EMPTY) | out_ready_i;

   assign cmd.addr = `CAM_FB_BASE;
   assign cmd.stream_length = cam_pkg::ddr_addr_t'(FRAME_PHRASES);
   assign cmd.wen = 1'b1;

   // pixel k lands in bits 16k..16k+15, the eighth comes straight from the input
   always_comb begin
      for (int k = 0; k < LAST_SLOT; k++) begin
         data_phrase[k*`CAM_PIX_W +: `CAM_PIX_W] = pack_q[k];
      end
      data_phrase[LAST_SLOT*`CAM_PIX_W +: `CAM_PIX_W] = coord_pix_i.data;
   end

   always_comb begin
      if (load_cmd) begin
         next_beat.tuser = 1'b1;
         next_beat.data = {{CMD_PAD{1'b0}}, cmd};
      end else begin
         next_beat.tuser = 1'b0;
         next_beat.data = data_phrase;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (sys_rst) begin
         freeze_q <= 1'b0;
         slot_q <= '0;
      end else if (coord_pix_i.valid) begin
         if (new_frame) begin
            freeze_q <= freeze_i;
         end
         if (frame_live) begin
            slot_q <= slot_base + 1'b1;
         end else begin
            slot_q <= slot_base;
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (coord_pix_i.valid && frame_live && slot_base != SLOT_W'(LAST_SLOT)) begin
         pack_q[slot_base] <= coord_pix_i.data;
      end
   end

   // single output register, a phrase that finds it busy is lost and counted
   always_ff @(posedge sys_clk) begin
      if (sys_rst) begin
         state <= cam_pkg::OUT_EMPTY;
         drop_count_o <= '0;
      end else begin
         case (state)
            cam_pkg::OUT_EMPTY: begin
               if (load_any) begin
                  state <= cam_pkg::OUT_FULL;
               end
            end
            cam_pkg::OUT_FULL: begin
               if (out_ready_i && !load_any) begin
                  state <= cam_pkg::OUT_EMPTY;
               end
            end
         endcase
         if (load_any && !can_load && drop_count_o != '1) begin
            drop_count_o <= drop_count_o + 1'b1;
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (load_any && can_load) begin
         beat_q <= next_beat;
      end
   end

   assign out_valid_o = (state == cam_pkg::OUT_FULL);
   assign out_beat_o = beat_q;

endmodule

`default_nettype wire

//--- cam_coord_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module cam_coord_tracker (
   input  logic                  sys_clk,
   input  logic                  sys_rst,
   input  logic                  pix_valid_i,
   input  cam_pkg::pixel_t       pix_data_i,
   input  logic                  line_active_i,
   input  logic                  frame_blank_i,
   output cam_pkg::coord_pixel_t coord_pix_o
);

   cam_pkg::hcount_t hcount_q;
   cam_pkg::vcount_t vcount_q;
   logic line_prev;
   logic valid_q;
   logic newframe_q;
   cam_pkg::hcount_t hcount_out;
   cam_pkg::vcount_t vcount_out;
   cam_pkg::pixel_t data_q;

   // position of the next pixel to arrive
   always_ff @(posedge sys_clk) begin
      if (sys_rst) begin
         hcount_q <= '0;
         vcount_q <= '0;
         line_prev <= 1'b0;
         valid_q <= 1'b0;
      end else begin
         line_prev <= line_active_i;
         valid_q <= pix_valid_i;
         if (frame_blank_i) begin
            hcount_q <= '0;
            vcount_q <= '0;
         end else if (line_prev && !line_active_i) begin
            // end of a line
            hcount_q <= '0;
            vcount_q <= vcount_q + 1'b1;
         end else if (pix_valid_i) begin
            hcount_q <= hcount_q + 1'b1;
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (pix_valid_i) begin
         newframe_q <= (hcount_q == '0) && (vcount_q == '0);
         hcount_out <= hcount_q;
         vcount_out <= vcount_q;
         data_q <= pix_data_i;
      end
   end

   assign coord_pix_o = '{
      valid:    valid_q,
      newframe: newframe_q,
      hcount:   hcount_out,
      vcount:   vcount_out,
      data:     data_q
   };

endmodule

`default_nettype wire

//--- cam_byte_pairer.sv
`timescale 1ns/1ps
`include "cam_settings.svh"
`default_nettype none

module cam_byte_pairer (
   input  logic               sys_clk,
   input  logic               sys_rst,
   input  logic               cam_pclk_i,
   input  logic               cam_hs_i,
   input  logic               cam_vs_i,
   input  cam_pkg::cam_byte_t cam_data_i,
   output logic               pix_valid_o,
   output cam_pkg::pixel_t    pix_data_o,
   output logic               line_active_o,
   output logic               frame_blank_o
);

   localparam int SYNC_W = `CAM_BYTE_W + 3;

   // camera pins bundled as {pclk, hs, vs, data}
   logic [SYNC_W-1:0] sync_q [`CAM_SYNC_STAGES];
   logic [SYNC_W-1:0] sync_out;
   logic pclk_s;
   logic pclk_prev;
   logic pclk_rise_q;
   cam_pkg::cam_byte_t byte_q;
   cam_pkg::cam_byte_t high_byte;
   cam_pkg::cam_byte_t low_byte;
   cam_pkg::byte_phase_t phase;
   logic pair_done;

   always_ff @(posedge sys_clk) begin
      if (sys_rst) begin
         for (int i = 0; i < `CAM_SYNC_STAGES; i++) begin
            sync_q[i] <= '0;
         end
      end else begin
         sync_q[0] <= {cam_pclk_i, cam_hs_i, cam_vs_i, cam_data_i};
         for (int i = 1; i < `CAM_SYNC_STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
      end
   end

   assign sync_out = sync_q[`CAM_SYNC_STAGES-1];
   assign pclk_s = sync_out[SYNC_W-1];
   assign line_active_o = sync_out[SYNC_W-2];
   assign frame_blank_o = sync_out[SYNC_W-3];

   // registered rising edge of pclk, only counted inside a line
   always_ff @(posedge sys_clk) begin
      if (sys_rst) begin
         pclk_prev <= 1'b0;
         pclk_rise_q <= 1'b0;
      end else begin
         pclk_prev <= pclk_s;
         pclk_rise_q <= pclk_s & ~pclk_prev & line_active_o;
      end
   end

   // byte travels alongside the edge register
   always_ff @(posedge sys_clk) begin
      byte_q <= sync_out[`CAM_BYTE_W-1:0];
   end

   always_ff @(posedge sys_clk) begin
      if (sys_rst) begin
         phase <= cam_pkg::PHASE_HIGH;
         pair_done <= 1'b0;
         pix_valid_o <= 1'b0;
      end else begin
         pair_done <= 1'b0;
         pix_valid_o <= pair_done;
         if (!line_active_o) begin
            phase <= cam_pkg::PHASE_HIGH;
         end else if (pclk_rise_q) begin
            if (phase == cam_pkg::PHASE_HIGH) begin
               phase <= cam_pkg::PHASE_LOW;
            end else begin
               phase <= cam_pkg::PHASE_HIGH;
               pair_done <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (pclk_rise_q && phase == cam_pkg::PHASE_HIGH) begin
         high_byte <= byte_q;
      end
      if (pclk_rise_q && phase == cam_pkg::PHASE_LOW) begin
         low_byte <= byte_q;
      end
      if (pair_done) begin
         pix_data_o <= {high_byte, low_byte};
      end
   end

endmodule

`default_nettype wire

//--- cam_pkg.sv
`include "cam_settings.svh"
`default_nettype none

package cam_pkg;

   typedef logic [`CAM_BYTE_W-1:0] cam_byte_t;
   typedef logic [`CAM_PIX_W-1:0] pixel_t;
   typedef logic [`CAM_PHRASE_W-1:0] phrase_t;
   typedef logic [`CAM_ADDR_W-1:0] ddr_addr_t;
   typedef logic [`CAM_HCOUNT_W-1:0] hcount_t;
   typedef logic [`CAM_VCOUNT_W-1:0] vcount_t;
   typedef logic [`CAM_DROP_W-1:0] drop_count_t;

   // pixel with its position, tracker to builder
   typedef struct packed {
      logic    valid;
      logic    newframe;
      hcount_t hcount;
      vcount_t vcount;
      pixel_t  data;
   } coord_pixel_t;

   // write command, sits in the low bits of a tuser phrase
   typedef struct packed {
      ddr_addr_t addr;
      ddr_addr_t stream_length;
      logic      wen;
   } channel_update_t;

   typedef struct packed {
      logic    tuser;
      phrase_t data;
   } phrase_beat_t;

   typedef enum logic {
      PHASE_HIGH = 1'b0,
      PHASE_LOW  = 1'b1
   } byte_phase_t;

   typedef enum logic {
      OUT_EMPTY = 1'b0,
      OUT_FULL  = 1'b1
   } out_state_t;

endpackage

`default_nettype wire

//--- cam_settings.svh
`ifndef CAM_SETTINGS_SVH
`define CAM_SETTINGS_SVH
`default_nettype none

// camera and pixel widths
`define CAM_BYTE_W 8
`define CAM_PIX_W 16

// memory phrase layout, eight RGB565 pixels per phrase
`define CAM_PHRASE_W 128
`define CAM_PIX_PER_PHRASE 8
`define CAM_ADDR_W 27

// coordinate counter widths
`define CAM_HCOUNT_W 13
`define CAM_VCOUNT_W 12

// reduced frame so a simulation run stays short
`define CAM_FRAME_W 16
`define CAM_FRAME_H 4

`define CAM_FB_BASE 27'h1000
`define CAM_SYNC_STAGES 2
`define CAM_DROP_W 8

`default_nettype wire
`endif
